/* sources.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/InstructionDecoder.sv
rtl/Alu.sv
rtl/RegFile.sv
rtl/BaudTimer.sv
rtl/SerialTx.sv
rtl/Mips150.sv
testbench/tb_ClockGen.sv
testbench/Mips150_sva.sv
testbench/tb_Mips150.sv

/* Bender.yml */
package:
  name: mips150

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/InstructionDecoder.sv
      - rtl/Alu.sv
      - rtl/RegFile.sv
      - rtl/BaudTimer.sv
      - rtl/SerialTx.sv
      - rtl/Mips150.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_ClockGen.sv
      - testbench/Mips150_sva.sv
      - testbench/tb_Mips150.sv

/* testbench/tb_Mips150.sv */
`timescale 1ns/1ns
`include "mips_settings.svh"

module tb_Mips150;
  import mips_pkg::*;

  // MIPS opcodes and function codes
  localparam logic [5:0] opBeq = 6'h04;
  localparam logic [5:0] opBne = 6'h05;
  localparam logic [5:0] opAddiu = 6'h09;
  localparam logic [5:0] opAndi = 6'h0c;
  localparam logic [5:0] opOri = 6'h0d;
  localparam logic [5:0] opLui = 6'h0f;
  localparam logic [5:0] opLw = 6'h23;
  localparam logic [5:0] opSw = 6'h2b;
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSubu = 6'h23;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr = 6'h25;
  localparam logic [5:0] fnXor = 6'h26;
  localparam logic [5:0] fnSlt = 6'h2a;

  localparam int resetCycles = 16;
  localparam int progLen = 66;
  localparam word_t opA = 32'hF0F0_1234;
  localparam word_t opB = 32'h0F0F_5678;
  localparam word_t storeBase = 32'h0000_0100;
  localparam word_t loadAddr = 32'h0000_0040;
  localparam word_t statusAddr = `MIPS_STATUS_ADDR;
  localparam word_t txAddr = `MIPS_TX_ADDR;
  localparam logic [15:0] txOffset = 16'(txAddr - statusAddr);
  localparam logic [15:0] negImm = 16'h8765;
  localparam logic [7:0] byte0 = 8'hA5;
  localparam logic [7:0] byte1 = 8'h3C;
  localparam bit kindStore = 1'b0;
  localparam bit kindSerial = 1'b1;

  logic clk;
  logic rst = 1'b1;
  logic stall = 1'b0;
  word_t instruction = '0;
  word_t dmemDout = '0;
  word_t instrAddr;
  word_t dmemAddr;
  logic [3:0] dmemWe;
  logic dmemRe;
  word_t dmemDin;
  logic txd;

  word_t rom [0:127];
  word_t dmem [0:127];

  // Expectation table with one row per store or serial byte in program order
  bit expKind [$];
  word_t expAddr [$];
  word_t expData [$];
  string expName [$];

  // Observed events in arrival order
  bit evKind [$];
  word_t evAddr [$];
  word_t evData [$];

  bit tablesReady = 1'b0;
  bit stallOn = 1'b0;
  logic [31:0] rngState = 32'd67910;

  tb_ClockGen #(
    .periodNs(100)
  ) u_clockGen (
    .clk(clk)
  );

  Mips150 #(
    .baudDiv(`MIPS_BAUD_DIV)
  ) u_dut (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .instruction(instruction),
    .dmemDout(dmemDout),
    .instrAddr(instrAddr),
    .dmemAddr(dmemAddr),
    .dmemWe(dmemWe),
    .dmemRe(dmemRe),
    .dmemDin(dmemDin),
    .txd(txd)
  );

  bind Mips150 Mips150_sva u_sva (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .dmemWe(dmemWe),
    .dmemAddr(dmemAddr),
    .txd(txd)
  );

  // ********************
  // Helpers
  // ********************

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t rType(int rs, int rt, int rd, int shamt, logic [5:0] funct);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
  endfunction

  function automatic word_t iType(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // Preload pattern that differs for every word index
  function automatic word_t fillWord(int idx);
    return 32'hC0DE_0000 ^ (32'(idx) * 32'h0101_0101);
  endfunction

  function automatic string kindName(bit kind);
    return kind ? "serial" : "store";
  endfunction

  task automatic abortRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic expectStore(string name, word_t offset, word_t data);
    expKind.push_back(kindStore);
    expAddr.push_back(storeBase + offset);
    expData.push_back(data);
    expName.push_back(name);
  endtask

  task automatic expectByte(string name, logic [7:0] b);
    expKind.push_back(kindSerial);
    expAddr.push_back(txAddr);
    expData.push_back({24'h0, b});
    expName.push_back(name);
  endtask

  // ********************
  // Program and expectations
  // ********************

  task automatic loadProgram();
    for (int i = 0; i < 128; i++) begin
      rom[i] = '0;
      dmem[i] = fillWord(i);
    end
    // Operands where each ori takes the lui result by forwarding
    rom[0] = iType(opLui, 0, 1, opA[31:16]);
    rom[1] = iType(opOri, 1, 1, opA[15:0]);
    rom[2] = iType(opLui, 0, 2, opB[31:16]);
    rom[3] = iType(opOri, 2, 2, opB[15:0]);
    rom[4] = iType(opAddiu, 0, 20, storeBase[15:0]);
    rom[5] = rType(1, 2, 3, 0, fnAddu);
    rom[6] = rType(1, 2, 4, 0, fnSubu);
    rom[7] = rType(1, 2, 5, 0, fnAnd);
    rom[8] = rType(1, 2, 6, 0, fnOr);
    rom[9] = rType(1, 2, 7, 0, fnXor);
    rom[10] = rType(1, 2, 8, 0, fnSlt);
    rom[11] = rType(0, 1, 12, 4, fnSll);
    rom[12] = rType(0, 2, 13, 7, fnSrl);
    rom[13] = iType(opSw, 20, 1, 16'd0);
    rom[14] = iType(opSw, 20, 2, 16'd4);
    rom[15] = iType(opSw, 20, 3, 16'd8);
    rom[16] = iType(opSw, 20, 4, 16'd12);
    rom[17] = iType(opSw, 20, 5, 16'd16);
    rom[18] = iType(opSw, 20, 6, 16'd20);
    rom[19] = iType(opSw, 20, 7, 16'd24);
    rom[20] = iType(opSw, 20, 8, 16'd28);
    rom[21] = iType(opSw, 20, 12, 16'd32);
    rom[22] = iType(opSw, 20, 13, 16'd36);
    // Immediates with each result stored right away
    rom[23] = iType(opAddiu, 1, 14, negImm);
    rom[24] = iType(opSw, 20, 14, 16'd40);
    rom[25] = iType(opAndi, 1, 15, negImm);
    rom[26] = iType(opSw, 20, 15, 16'd44);
    rom[27] = iType(opOri, 2, 16, 16'hA5A5);
    rom[28] = iType(opSw, 20, 16, 16'd48);
    rom[29] = iType(opLui, 0, 17, 16'hBEEF);
    rom[30] = iType(opSw, 20, 17, 16'd52);
    rom[31] = rType(1, 2, 18, 0, fnAddu);
    rom[32] = iType(opSw, 20, 18, 16'd56);
    rom[33] = rType(18, 2, 19, 0, fnSubu);
    rom[34] = iType(opSw, 20, 19, 16'd60);
    // Load with one spacer before the use
    rom[35] = iType(opLw, 0, 21, loadAddr[15:0]);
    rom[36] = iType(opAddiu, 0, 22, 16'd1);
    rom[37] = iType(opAddiu, 21, 23, 16'h0123);
    rom[38] = iType(opSw, 20, 23, 16'd64);
    // Branches with the stores at 41 and 47 in skipped slots
    rom[39] = iType(opBeq, 1, 1, 16'd2);
    rom[40] = iType(opSw, 20, 1, 16'd68);
    rom[41] = iType(opSw, 20, 7, 16'd96);
    rom[42] = iType(opBne, 1, 1, 16'd2);
    rom[43] = iType(opSw, 20, 2, 16'd72);
    rom[44] = iType(opSw, 20, 3, 16'd76);
    rom[45] = iType(opBne, 1, 2, 16'd2);
    rom[46] = iType(opSw, 20, 4, 16'd80);
    rom[47] = iType(opSw, 20, 8, 16'd100);
    rom[48] = iType(opBeq, 1, 2, 16'd2);
    rom[49] = iType(opSw, 20, 5, 16'd84);
    rom[50] = iType(opSw, 20, 6, 16'd88);
    // Serial output with status polling
    rom[51] = iType(opLui, 0, 9, statusAddr[31:16]);
    rom[52] = iType(opAddiu, 0, 11, {8'h00, byte0});
    rom[53] = iType(opLw, 9, 10, 16'd0);
    rom[54] = iType(opAddiu, 0, 22, 16'd2);
    rom[55] = iType(opBeq, 10, 0, 16'hFFFD);
    rom[56] = iType(opAddiu, 0, 24, {8'h00, byte1});
    rom[57] = iType(opSw, 9, 11, txOffset);
    rom[58] = iType(opLw, 9, 10, 16'd0);
    rom[59] = iType(opAddiu, 0, 22, 16'd3);
    rom[60] = iType(opBeq, 10, 0, 16'hFFFD);
    rom[61] = '0;
    rom[62] = iType(opSw, 9, 24, txOffset);
    rom[63] = iType(opSw, 20, 22, 16'd92);
    // Park in a self loop
    rom[64] = iType(opBeq, 0, 0, 16'hFFFF);
    rom[65] = '0;
  endtask

  task automatic buildExpectations();
    expectStore("lui ori forwarded", 0, opA);
    expectStore("lui ori", 4, opB);
    expectStore("addu", 8, opA + opB);
    expectStore("subu", 12, opA - opB);
    expectStore("and", 16, opA & opB);
    expectStore("or", 20, opA | opB);
    expectStore("xor", 24, opA ^ opB);
    expectStore("slt", 28, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
    expectStore("sll", 32, opA << 4);
    expectStore("srl", 36, opB >> 7);
    expectStore("addiu", 40, opA + {{16{negImm[15]}}, negImm});
    expectStore("andi", 44, opA & {16'h0000, negImm});
    expectStore("ori", 48, opB | 32'h0000_A5A5);
    expectStore("lui", 52, 32'hBEEF_0000);
    expectStore("addu back to back", 56, opA + opB);
    expectStore("subu back to back", 60, (opA + opB) - opB);
    expectStore("lw then addiu", 64, fillWord(loadAddr / 4) + 32'h0000_0123);
    expectStore("beq taken delay slot", 68, opA);
    expectStore("bne untaken delay slot", 72, opB);
    expectStore("bne untaken fall through", 76, opA + opB);
    expectStore("bne taken delay slot", 80, opA - opB);
    expectStore("beq untaken delay slot", 84, opA & opB);
    expectStore("beq untaken fall through", 88, opA | opB);
    expectByte("serial byte 0", byte0);
    expectStore("store after poll", 92, 32'd3);
    expectByte("serial byte 1", byte1);
  endtask

  // ********************
  // Memory models and monitors
  // ********************

  // Synchronous instruction ROM
  always @(posedge clk) begin
    instruction <= rom[instrAddr[8:2]];
  end

  always @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      if (dmemWe[k]) begin
        dmem[dmemAddr[8:2]][8*k +: 8] <= dmemDin[8*k +: 8];
      end
    end
    if (dmemRe) begin
      dmemDout <= dmem[dmemAddr[8:2]];
    end
  end

  always @(posedge clk) begin
    if (stallOn) begin
      rngState = xorshift32(rngState);
      stall <= (rngState[1:0] == 2'b00);
    end
  end

  // Data port monitor sampled mid-cycle
  always @(negedge clk) begin
    assert (u_dut.u_sva.errorCount == 0) else begin
      $display("A bound assertion on the core's ports failed");
      abortRun();
    end
    // The program has a single load that goes to the data port
    if (!rst && dmemRe) begin
      assert (dmemAddr == loadAddr) else begin
        $display("CHECK FAILED data port read address: expected 0x%h, actual 0x%h",
                 loadAddr, dmemAddr);
        abortRun();
      end
    end
    if (!rst && dmemWe != 4'b0000) begin
      assert (dmemWe == 4'b1111) else begin
        $display("CHECK FAILED store byte mask: expected 1111, actual %b", dmemWe);
        abortRun();
      end
      evKind.push_back(kindStore);
      evAddr.push_back(dmemAddr);
      evData.push_back(dmemDin);
    end
  end

  initial begin : serialMonitor
    logic [7:0] rxByte;
    wait (!rst);
    forever begin
      @(negedge clk);
      if (txd === 1'b0) begin
        repeat (`MIPS_BAUD_DIV / 2) @(negedge clk);
        assert (txd === 1'b0) else begin
          $display("Serial start bit did not stay low until mid-bit");
          abortRun();
        end
        // LSB first
        for (int b = 0; b < 8; b++) begin
          repeat (`MIPS_BAUD_DIV) @(negedge clk);
          rxByte[b] = txd;
        end
        repeat (`MIPS_BAUD_DIV) @(negedge clk);
        assert (txd === 1'b1) else begin
          $display("Serial stop bit was not high");
          abortRun();
        end
        evKind.push_back(kindSerial);
        evAddr.push_back(txAddr);
        evData.push_back({24'h0, rxByte});
      end
    end
  end

  // ********************
  // Main sequence
  // ********************

  initial begin : watchdog
    int limit;
    wait (tablesReady);
    limit = resetCycles + progLen * 40 + expByteCount() * 10 * `MIPS_BAUD_DIV;
    repeat (limit) @(posedge clk);
    $display("Timeout: expected stores and serial bytes did not all arrive in %0d cycles",
             limit);
    abortRun();
  end

  function automatic int expByteCount();
    int n;
    n = 0;
    foreach (expKind[i]) begin
      if (expKind[i] == kindSerial) begin
        n++;
      end
    end
    return n;
  endfunction

  initial begin : mainSequence
    bit gotKind;
    word_t gotAddr;
    word_t gotData;
    loadProgram();
    buildExpectations();
    tablesReady = 1'b1;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;

    // Events arrive at falling edges and are taken at the next rising edge
    for (int i = 0; i < expKind.size(); i++) begin
      while (evKind.size() == 0) begin
        @(posedge clk);
      end
      gotKind = evKind.pop_front();
      gotAddr = evAddr.pop_front();
      gotData = evData.pop_front();
      assert (gotKind == expKind[i] && gotAddr == expAddr[i] && gotData == expData[i])
      else begin
        $display("CHECK FAILED %s: expected %s addr 0x%h data 0x%h, actual %s addr 0x%h data 0x%h",
                 expName[i], kindName(expKind[i]), expAddr[i], expData[i],
                 kindName(gotKind), gotAddr, gotData);
        abortRun();
      end
      // Random stalls over the second half of the program
      if (i == expKind.size() / 2) begin
        stallOn <= 1'b1;
      end
    end

    repeat (20) @(negedge clk);
    assert (evKind.size() == 0) else begin
      $display("Unexpected store or serial byte after the last expected one");
      abortRun();
    end
    if (u_dut.u_sva.errorCount == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Bound assertions reported %0d failures", u_dut.u_sva.errorCount);
      abortRun();
    end
  end

endmodule

/* testbench/Mips150_sva.sv */
`timescale 1ns/1ns
`include "mips_settings.svh"

module Mips150_sva (
  input logic            clk,
  input logic            rst,
  input logic            stall,
  input logic [3:0]      dmemWe,
  input mips_pkg::word_t dmemAddr,
  input logic            txd
);

  int unsigned errorCount = 0;

  // No byte enable may leave the core while the pipeline is frozen
  noWriteInStall: assert property (@(posedge clk) disable iff (rst) stall |-> dmemWe == 4'b0000)
    else begin
      $error("dmemWe is nonzero while stall is high");
      errorCount++;
    end

  // Serial line idles high once reset is released
  txdIdleAfterReset: assert property (@(posedge clk) $fell(rst) |-> txd)
    else begin
      $error("txd is not high in the first cycle after reset");
      errorCount++;
    end

  // Transmitter stores stay off the data port
  noTxOnDataPort: assert property (@(posedge clk) disable iff (rst)
    (dmemWe != 4'b0000) |-> (dmemAddr != `MIPS_TX_ADDR))
    else begin
      $error("Data port write seen at the transmit address");
      errorCount++;
    end

endmodule

/* testbench/tb_ClockGen.sv */
`timescale 1ns/1ns

module tb_ClockGen #(
  parameter int periodNs = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Free running, first rising edge at half a period
  always #(periodNs / 2) clk = ~clk;

endmodule

/* rtl/Mips150.sv */
`timescale 1ns/1ns
`include "mips_settings.svh"

module Mips150 #(
  parameter int baudDiv = `MIPS_BAUD_DIV
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall,
  input  mips_pkg::word_t instruction,
  input  mips_pkg::word_t dmemDout,
  output mips_pkg::word_t instrAddr,
  output mips_pkg::word_t dmemAddr,
  output logic [3:0]      dmemWe,
  output logic            dmemRe,
  output mips_pkg::word_t dmemDin,
  output logic            txd
);
  import mips_pkg::*;

  function automatic logic [3:0] byteMask(memSize_t size);
    case (size)
      memByte: return 4'b0001;
      memHalf: return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // ********************
  // Fetch
  // ********************

  word_t pcD;
  logic validD;
  logic takenE;
  word_t targetE;

  // Stall repeats the last address so the ROM returns the same word
  assign instrAddr = stall ? pcD :
                     takenE ? targetE :
                     validD ? pcD + 32'd4 : pcD;

  always_ff @(posedge clk) begin
    if (rst) begin
      pcD <= `MIPS_RESET_PC;
      validD <= 1'b0;
    end else if (!stall) begin
      pcD <= instrAddr;
      validD <= 1'b1;
    end
  end

  // ********************
  // Decode
  // ********************

  word_t instrD;
  word_t immD;
  aluOp_t aluOpD;
  logic aluSrcD, shiftImmD, regDstD, regWriteD;
  logic memWriteD, memToRegD, branchD, branchNeD;

  // First word after reset is a bubble
  assign instrD = validD ? instruction : '0;

  InstructionDecoder u_decoder (
    .instruction(instrD),
    .aluOp(aluOpD),
    .aluSrc(aluSrcD),
    .shiftImm(shiftImmD),
    .regDst(regDstD),
    .regWrite(regWriteD),
    .memWrite(memWriteD),
    .memToReg(memToRegD),
    .branch(branchD),
    .branchNe(branchNeD),
    .immExt(immD)
  );

  // ********************
  // Execute
  // ********************

  word_t instrE, pcE, immE;
  aluOp_t aluOpE;
  logic aluSrcE, shiftImmE, regDstE, regWriteE;
  logic memWriteE, memToRegE, branchE, branchNeE;

  always_ff @(posedge clk) begin
    if (rst) begin
      instrE <= '0;
      aluOpE <= aluAdd;
      {aluSrcE, shiftImmE, regDstE, regWriteE} <= 4'b0000;
      {memWriteE, memToRegE, branchE, branchNeE} <= 4'b0000;
    end else if (!stall) begin
      instrE <= instrD;
      pcE <= pcD;
      immE <= immD;
      aluOpE <= aluOpD;
      {aluSrcE, shiftImmE, regDstE, regWriteE} <= {aluSrcD, shiftImmD, regDstD, regWriteD};
      {memWriteE, memToRegE, branchE, branchNeE} <= {memWriteD, memToRegD, branchD, branchNeD};
    end
  end

  regAddr_t rsE, rtE, rdE, waE, waM;
  word_t rsData, rtData, rsVal, rtVal, aluA, aluB, aluOutE, aluOutM, wbData;
  logic regWriteM, memToRegM, mFresh, fwdM;

  assign rsE = instrE[25:21];
  assign rtE = instrE[20:16];
  assign rdE = instrE[15:11];
  assign waE = regDstE ? rdE : rtE;

  RegFile u_regFile (
    .clk(clk),
    .we(regWriteM & mFresh),
    .ra1(rsE),
    .ra2(rtE),
    .wa(waM),
    .wd(wbData),
    .rd1(rsData),
    .rd2(rtData)
  );

  // Only ALU results forward, loads need a spacer instruction
  assign fwdM = regWriteM & ~memToRegM & (waM != 5'd0);
  assign rsVal = (fwdM && waM == rsE) ? aluOutM : rsData;
  assign rtVal = (fwdM && waM == rtE) ? aluOutM : rtData;

  assign aluA = shiftImmE ? {27'b0, instrE[10:6]} : rsVal;
  assign aluB = aluSrcE ? immE : rtVal;

  Alu u_alu (
    .a(aluA),
    .b(aluB),
    .aluOp(aluOpE),
    .result(aluOutE)
  );

  // Target is relative to the delay slot
  assign targetE = pcE + 32'd4 + {immE[29:0], 2'b00};
  assign takenE = branchE & ((rsVal == rtVal) ^ branchNeE);

  // Memory map
  logic isTxE, isStatusE, isIoE, txValid, txReady;

  assign isTxE = (aluOutE == `MIPS_TX_ADDR);
  assign isStatusE = (aluOutE == `MIPS_STATUS_ADDR);
  assign isIoE = isTxE | isStatusE;

  assign dmemAddr = aluOutE;
  assign dmemDin = rtVal;
  assign dmemWe = (memWriteE & ~isIoE & ~stall) ? byteMask(memWord) : 4'b0000;
  assign dmemRe = memToRegE & ~isIoE;
  assign txValid = memWriteE & isTxE & ~stall;

  SerialTx #(
    .baudDiv(baudDiv)
  ) u_serialTx (
    .clk(clk),
    .rst(rst),
    .txValid(txValid),
    .txByte(rtVal[7:0]),
    .txReady(txReady),
    .txd(txd)
  );

  // ********************
  // Memory / writeback
  // ********************

  logic ioLoadM, statusM;

  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteM <= 1'b0;
      memToRegM <= 1'b0;
      mFresh <= 1'b0;
    end else begin
      mFresh <= !stall;
      if (!stall) begin
        regWriteM <= regWriteE;
        memToRegM <= memToRegE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      waM <= waE;
      aluOutM <= aluOutE;
      ioLoadM <= isIoE;
      statusM <= txReady;
    end
  end

  // Register write happens once, in the first cycle of the stage
  assign wbData = !memToRegM ? aluOutM :
                  ioLoadM ? {31'b0, statusM} : dmemDout;

endmodule

/* rtl/SerialTx.sv */
`timescale 1ns/1ns
`include "mips_settings.svh"

module SerialTx #(
  parameter int baudDiv = `MIPS_BAUD_DIV
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       txValid,
  input  logic [7:0] txByte,
  output logic       txReady,
  output logic       txd
);
  import mips_pkg::*;

  txState_t state;
  logic [7:0] shiftReg;
  logic [2:0] bitIdx;
  logic timerEn;
  logic tick;

  assign timerEn = (state != txIdle);

  BaudTimer #(
    .baudDiv(baudDiv)
  ) u_baudTimer (
    .clk(clk),
    .rst(rst),
    .enable(timerEn),
    .tick(tick)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= txIdle;
      bitIdx <= 3'd0;
    end else begin
      case (state)
        txIdle: begin
          if (txValid) begin
            shiftReg <= txByte;
            state <= txStart;
          end
        end
        txStart: begin
          if (tick) begin
            bitIdx <= 3'd0;
            state <= txData;
          end
        end
        // Data goes out LSB first
        txData: begin
          if (tick) begin
            shiftReg <= shiftReg >> 1;
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == 3'd7) begin
              state <= txStop;
            end
          end
        end
        txStop: begin
          if (tick) begin
            state <= txIdle;
          end
        end
        default: state <= txIdle;
      endcase
    end
  end

  assign txReady = (state == txIdle);

  always_comb begin
    case (state)
      txStart: txd = 1'b0;
      txData: txd = shiftReg[0];
      default: txd = 1'b1;
    endcase
  end

endmodule

/* rtl/BaudTimer.sv */
`timescale 1ns/1ns
`include "mips_settings.svh"

module BaudTimer #(
  parameter int baudDiv = `MIPS_BAUD_DIV
) (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  output logic tick
);

  localparam int countW = (baudDiv > 1) ? $clog2(baudDiv) : 1;

  logic [countW-1:0] count;

  // Counts down while enabled, reloads at zero
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      count <= countW'(baudDiv - 1);
    end else if (count == '0) begin
      count <= countW'(baudDiv - 1);
    end else begin
      count <= count - 1'b1;
    end
  end

  assign tick = enable && (count == '0);

endmodule

/* rtl/RegFile.sv */
`timescale 1ns/1ns

module RegFile (
  input  logic              clk,
  input  logic              we,
  input  mips_pkg::regAddr_t ra1,
  input  mips_pkg::regAddr_t ra2,
  input  mips_pkg::regAddr_t wa,
  input  mips_pkg::word_t   wd,
  output mips_pkg::word_t   rd1,
  output mips_pkg::word_t   rd2
);
  import mips_pkg::*;

  word_t regs [31:1];

  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // Register 0 is hardwired to zero
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* rtl/Alu.sv */
`timescale 1ns/1ns

module Alu (
  input  mips_pkg::word_t  a,
  input  mips_pkg::word_t  b,
  input  mips_pkg::aluOp_t aluOp,
  output mips_pkg::word_t  result
);
  import mips_pkg::*;

  always_comb begin
    case (aluOp)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr: result = a | b;
      aluXor: result = a ^ b;
      aluSlt: result = {31'b0, $signed(a) < $signed(b)};
      // Shift amount arrives on a, the shifted value on b
      aluSll: result = b << a[4:0];
      aluSrl: result = b >> a[4:0];
      aluLui: result = b;
      default: result = '0;
    endcase
  end

endmodule

/* rtl/InstructionDecoder.sv */
`timescale 1ns/1ns

module InstructionDecoder (
  input  mips_pkg::word_t  instruction,
  output mips_pkg::aluOp_t aluOp,
  output logic             aluSrc,
  output logic             shiftImm,
  output logic             regDst,
  output logic             regWrite,
  output logic             memWrite,
  output logic             memToReg,
  output logic             branch,
  output logic             branchNe,
  output mips_pkg::word_t  immExt
);
  import mips_pkg::*;

  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opBeq = 6'h04;
  localparam logic [5:0] opBne = 6'h05;
  localparam logic [5:0] opAddiu = 6'h09;
  localparam logic [5:0] opAndi = 6'h0c;
  localparam logic [5:0] opOri = 6'h0d;
  localparam logic [5:0] opLui = 6'h0f;
  localparam logic [5:0] opLw = 6'h23;
  localparam logic [5:0] opSw = 6'h2b;

  logic [5:0] opcode;
  logic [5:0] funct;
  logic [15:0] imm;

  assign opcode = instruction[31:26];
  assign funct = instruction[5:0];
  assign imm = instruction[15:0];

  always_comb begin
    aluOp = aluAdd;
    aluSrc = 1'b0;
    shiftImm = 1'b0;
    regDst = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    branch = 1'b0;
    branchNe = 1'b0;
    case (opcode)
      opRType: begin
        regDst = 1'b1;
        regWrite = 1'b1;
        case (funct)
          6'h21: aluOp = aluAdd;
          6'h23: aluOp = aluSub;
          6'h24: aluOp = aluAnd;
          6'h25: aluOp = aluOr;
          6'h26: aluOp = aluXor;
          6'h2a: aluOp = aluSlt;
          6'h00: begin
            aluOp = aluSll;
            shiftImm = 1'b1;
          end
          6'h02: begin
            aluOp = aluSrl;
            shiftImm = 1'b1;
          end
          // Unknown funct runs as a no-op
          default: regWrite = 1'b0;
        endcase
      end
      opAddiu, opAndi, opOri, opLui: begin
        aluSrc = 1'b1;
        regWrite = 1'b1;
        if (opcode == opAndi) begin
          aluOp = aluAnd;
        end else if (opcode == opOri) begin
          aluOp = aluOr;
        end else if (opcode == opLui) begin
          aluOp = aluLui;
        end
      end
      opLw: begin
        aluSrc = 1'b1;
        regWrite = 1'b1;
        memToReg = 1'b1;
      end
      opSw: begin
        aluSrc = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: branch = 1'b1;
      opBne: begin
        branch = 1'b1;
        branchNe = 1'b1;
      end
      default: ;
    endcase
  end

  // Logical immediates are zero extended, lui fills the upper half
  always_comb begin
    case (opcode)
      opLui: immExt = {imm, 16'h0000};
      opAndi, opOri: immExt = {16'h0000, imm};
      default: immExt = {{16{imm[15]}}, imm};
    endcase
  end

endmodule

/* rtl/mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regAddr_t;
  typedef logic [3:0] aluOp_t;
  typedef logic [1:0] memSize_t;

  // ALU operation codes
  localparam aluOp_t aluAdd = 4'd0;
  localparam aluOp_t aluSub = 4'd1;
  localparam aluOp_t aluAnd = 4'd2;
  localparam aluOp_t aluOr = 4'd3;
  localparam aluOp_t aluXor = 4'd4;
  localparam aluOp_t aluSlt = 4'd5;
  localparam aluOp_t aluSll = 4'd6;
  localparam aluOp_t aluSrl = 4'd7;
  localparam aluOp_t aluLui = 4'd8;

  // Access sizes on the data port
  localparam memSize_t memByte = 2'd0;
  localparam memSize_t memHalf = 2'd1;
  localparam memSize_t memWord = 2'd2;

  typedef enum logic [1:0] {
    txIdle,
    txStart,
    txData,
    txStop
  } txState_t;

endpackage

/* rtl/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// Memory-mapped serial transmitter
`define MIPS_TX_ADDR 32'h8000_0008
`define MIPS_STATUS_ADDR 32'h8000_0000

// Clock cycles per serial bit, kept short for simulation
`define MIPS_BAUD_DIV 8

`endif
